// File: source/alu_defs.svh
// Width, lane, buffer depth and saturation limit macros for the ALU

`ifndef ALU_DEFS_SVH
`define ALU_DEFS_SVH

// --------------------
// Datapath widths
// --------------------

// Integer word
`define ALU_XLEN 32

// One signed polar lane
`define ALU_LANE_W 8

// Lanes packed in one word
`define ALU_LANES (`ALU_XLEN / `ALU_LANE_W)

// --------------------
// Pipeline sizing
// --------------------

// Entries between decode and execute
`define ALU_BUF_DEPTH 2

// --------------------
// Polar saturation
// --------------------

// Symmetric clamp range, -128 is never produced
`define ALU_SAT_MAX 127
`define ALU_SAT_MIN (-127)

`endif

// File: source/alu_ctrl_pkg.sv
// Operator encoding, result unit select and decoded control types

`include "alu_defs.svh"

package alu_ctrl_pkg;

    // --------------------
    // Operators
    // --------------------
    typedef enum logic [4:0] {
        // Arithmetic and logic
        ADD       = 5'd0,
        SUB       = 5'd1,
        AND       = 5'd2,
        OR        = 5'd3,
        XOR       = 5'd4,
        // Shifts by b[4:0]
        SLL       = 5'd5,
        SRL       = 5'd6,
        SRA       = 5'd7,
        // Set-less-than
        SLT       = 5'd8,
        SLTU      = 5'd9,
        // Branch compares
        EQ        = 5'd10,
        NE        = 5'd11,
        LT        = 5'd12,
        GE        = 5'd13,
        LTU       = 5'd14,
        GEU       = 5'd15,
        // Polar lane ops
        PL_F      = 5'd16,
        PL_R      = 5'd17,
        PL_ADDSAT = 5'd18,
        PL_SUBSAT = 5'd19
    } alu_op_e;

    // Source of the execute result
    typedef enum logic [2:0] {
        UNIT_ADDER = 3'd0,
        UNIT_LOGIC = 3'd1,
        UNIT_SHIFT = 3'd2,
        UNIT_CMP   = 3'd3,
        UNIT_POLAR = 3'd4
    } unit_e;

    // --------------------
    // Decoded request
    // --------------------
    typedef struct packed {
        unit_e   unit;
        alu_op_e op;
        logic    negate_b;
        logic    signed_cmp;
        logic    shift_left;
        logic    shift_arith;
        logic    is_branch;
    } alu_ctrl_t;

    // Control plus both operands
    typedef struct packed {
        alu_ctrl_t              ctrl;
        logic [`ALU_XLEN-1:0]   a;
        logic [`ALU_XLEN-1:0]   b;
    } dec_item_t;

endpackage

// File: source/alu_data_pkg.sv
// Word, lane and shift amount types with the request and response structs

`include "alu_defs.svh"

package alu_data_pkg;

    import alu_ctrl_pkg::*;

    // --------------------
    // Plain vectors
    // --------------------

    // Operand or result
    typedef logic [`ALU_XLEN-1:0] word_t;

    // One polar lane, two's complement
    typedef logic signed [`ALU_LANE_W-1:0] lane_t;

    // Shift amount, only the low bits of b
    typedef logic [$clog2(`ALU_XLEN)-1:0] shamt_t;

    // --------------------
    // Link payloads
    // --------------------

    // Incoming request
    typedef struct packed {
        alu_op_e op;
        word_t   a;
        word_t   b;
    } alu_req_t;

    // Outgoing response
    typedef struct packed {
        word_t result;
        logic  branch_taken;
    } alu_resp_t;

endpackage

// File: source/polar_lanes.sv
// Per-lane polar f, r, saturating add and saturating subtract with operator select

`timescale 1ns/1ps
`include "alu_defs.svh"

module polar_lanes (
    input  alu_data_pkg::word_t   a_i,
    input  alu_data_pkg::word_t   b_i,
    input  alu_ctrl_pkg::alu_op_e op_i,
    output alu_data_pkg::word_t   result_o
);

    import alu_ctrl_pkg::*;
    import alu_data_pkg::*;

    localparam int LW = `ALU_LANE_W;

    word_t f_res;
    word_t r_res;
    word_t add_res;
    word_t sub_res;

    // Clamp a full precision lane value into the symmetric range
    function automatic lane_t saturate(input logic signed [LW:0] value);
        if (value > `ALU_SAT_MAX) begin
            return lane_t'(`ALU_SAT_MAX);
        end
        if (value < `ALU_SAT_MIN) begin
            return lane_t'(`ALU_SAT_MIN);
        end
        return value[LW-1:0];
    endfunction

    for (genvar i = 0; i < `ALU_LANES; i++) begin : g_lane
        lane_t              la;
        lane_t              lb;
        logic [LW:0]        mag_a;
        logic [LW:0]        mag_b;
        logic [LW:0]        mag_min;
        logic signed [LW:0] sum;
        logic signed [LW:0] diff;

        assign la = a_i[i*LW +: LW];
        assign lb = b_i[i*LW +: LW];

        // Nine bit magnitudes so |-128| compares as 128
        assign mag_a   = la[LW-1] ? -{1'b1, la} : {1'b0, la};
        assign mag_b   = lb[LW-1] ? -{1'b1, lb} : {1'b0, lb};
        assign mag_min = (mag_a < mag_b) ? mag_a : mag_b;

        assign f_res[i*LW +: LW] = (la[LW-1] ^ lb[LW-1]) ? -mag_min[LW-1:0]
                                                        : mag_min[LW-1:0];

        // Hard decision, forced to 0 when the b lane is exactly 1
        assign r_res[i*LW +: LW] = ((lb != lane_t'(1)) && la[LW-1]) ? LW'(1) : '0;

        assign sum  = la + lb;
        assign diff = la - lb;

        assign add_res[i*LW +: LW] = saturate(sum);
        assign sub_res[i*LW +: LW] = saturate(diff);
    end

    always_comb begin
        unique case (op_i)
            PL_F:      result_o = f_res;
            PL_R:      result_o = r_res;
            PL_ADDSAT: result_o = add_res;
            PL_SUBSAT: result_o = sub_res;
            default:   result_o = '0;
        endcase
    end

endmodule

// File: source/alu_decode.sv
// Decode stage: operator to control mapping and one registered output slot

`timescale 1ns/1ps

module alu_decode (
    input  logic                   clk_i,
    input  logic                   reset_i,
    input  logic                   req_valid_i,
    input  alu_data_pkg::alu_req_t req_i,
    output logic                   req_ready_o,
    output logic                   dec_valid_o,
    output alu_ctrl_pkg::dec_item_t dec_o,
    input  logic                   dec_ready_i
);

    import alu_ctrl_pkg::*;

    alu_ctrl_t ctrl_d;
    logic      slot_valid_q;
    dec_item_t slot_q;
    logic      accept;

    // --------------------
    // Operator decode
    // --------------------
    always_comb begin
        ctrl_d    = '0;
        ctrl_d.op = req_i.op;
        unique case (req_i.op)
            ADD: ctrl_d.unit = UNIT_ADDER;
            SUB: begin
                ctrl_d.unit     = UNIT_ADDER;
                ctrl_d.negate_b = 1'b1;
            end
            AND, OR, XOR: ctrl_d.unit = UNIT_LOGIC;
            SLL: begin
                ctrl_d.unit       = UNIT_SHIFT;
                ctrl_d.shift_left = 1'b1;
            end
            SRL: ctrl_d.unit = UNIT_SHIFT;
            SRA: begin
                ctrl_d.unit        = UNIT_SHIFT;
                ctrl_d.shift_arith = 1'b1;
            end
            // Compares all go through the subtractor
            SLT, LT, GE: begin
                ctrl_d.unit       = UNIT_CMP;
                ctrl_d.negate_b   = 1'b1;
                ctrl_d.signed_cmp = 1'b1;
                ctrl_d.is_branch  = (req_i.op != SLT);
            end
            SLTU, EQ, NE, LTU, GEU: begin
                ctrl_d.unit      = UNIT_CMP;
                ctrl_d.negate_b  = 1'b1;
                ctrl_d.is_branch = (req_i.op != SLTU);
            end
            PL_F, PL_R, PL_ADDSAT, PL_SUBSAT: ctrl_d.unit = UNIT_POLAR;
            default: ;
        endcase
    end

    // --------------------
    // Output slot
    // --------------------

    // Free when empty or draining this cycle
    assign req_ready_o = ~slot_valid_q | dec_ready_i;
    assign accept      = req_valid_i & req_ready_o;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            slot_valid_q <= 1'b0;
        end else if (req_ready_o) begin
            slot_valid_q <= req_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            slot_q.ctrl <= ctrl_d;
            slot_q.a    <= req_i.a;
            slot_q.b    <= req_i.b;
        end
    end

    assign dec_valid_o = slot_valid_q;
    assign dec_o       = slot_q;

endmodule

// File: source/alu_buffer.sv
// Circular FIFO of decoded items with valid/ready on both sides

`timescale 1ns/1ps
`include "alu_defs.svh"

module alu_buffer #(
    parameter int DEPTH = `ALU_BUF_DEPTH
) (
    input  logic                    clk_i,
    input  logic                    reset_i,
    input  logic                    wr_valid_i,
    input  alu_ctrl_pkg::dec_item_t wr_item_i,
    output logic                    wr_ready_o,
    output logic                    rd_valid_o,
    output alu_ctrl_pkg::dec_item_t rd_item_o,
    input  logic                    rd_ready_i
);

    import alu_ctrl_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    dec_item_t        mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             do_wr;
    logic             do_rd;

    // Wrap at DEPTH, not at the pointer width
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign rd_valid_o = (count_q != '0);
    assign rd_item_o  = mem[rd_ptr_q];

    // Full still accepts when the head leaves in the same cycle
    assign wr_ready_o = (count_q != CNT_W'(DEPTH)) | rd_ready_i;

    assign do_wr = wr_valid_i & wr_ready_o;
    assign do_rd = rd_valid_o & rd_ready_i;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr_q <= next_ptr(wr_ptr_q);
            end
            if (do_rd) begin
                rd_ptr_q <= next_ptr(rd_ptr_q);
            end
            case ({do_wr, do_rd})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (do_wr) begin
            mem[wr_ptr_q] <= wr_item_i;
        end
    end

endmodule

// File: source/alu_execute.sv
// Execute stage: adder, logic, shifter, compares, polar lanes and response register

`timescale 1ns/1ps

module alu_execute (
    input  logic                    clk_i,
    input  logic                    reset_i,
    input  logic                    in_valid_i,
    input  alu_ctrl_pkg::dec_item_t in_item_i,
    output logic                    in_ready_o,
    output logic                    resp_valid_o,
    output alu_data_pkg::alu_resp_t resp_o,
    input  logic                    resp_ready_i
);

    import alu_ctrl_pkg::*;
    import alu_data_pkg::*;

    localparam int XLEN = $bits(word_t);

    alu_ctrl_t     ctrl;
    word_t         op_a;
    word_t         op_b;
    logic          ext_a;
    logic          ext_b;
    logic [XLEN:0] adder_b;
    logic [XLEN:0] adder_sum;
    logic          adder_zero;
    logic          less;
    shamt_t        shamt;
    word_t         a_rev;
    word_t         shift_in;
    logic [XLEN:0] shift_right;
    word_t         shift_rev;
    word_t         shift_out;
    word_t         logic_res;
    word_t         polar_res;
    word_t         result_d;
    logic          branch_d;

    assign ctrl = in_item_i.ctrl;
    assign op_a = in_item_i.a;
    assign op_b = in_item_i.b;

    // --------------------
    // Adder
    // --------------------

    // One extra bit so the top of a difference is the compare sign
    assign ext_a      = ctrl.signed_cmp & op_a[XLEN-1];
    assign ext_b      = ctrl.signed_cmp & op_b[XLEN-1];
    assign adder_b    = {ext_b, op_b} ^ {(XLEN + 1){ctrl.negate_b}};
    assign adder_sum  = {ext_a, op_a} + adder_b + {{XLEN{1'b0}}, ctrl.negate_b};
    assign adder_zero = ~|adder_sum[XLEN-1:0];
    assign less       = adder_sum[XLEN];

    // --------------------
    // Shifter
    // --------------------

    // Left shifts run right on the reversed word
    assign shamt       = op_b[$bits(shamt_t)-1:0];
    assign a_rev       = {<<{op_a}};
    assign shift_in    = ctrl.shift_left ? a_rev : op_a;
    assign shift_right = $signed({ctrl.shift_arith & shift_in[XLEN-1], shift_in}) >>> shamt;
    assign shift_rev   = {<<{shift_right[XLEN-1:0]}};
    assign shift_out   = ctrl.shift_left ? shift_rev : shift_right[XLEN-1:0];

    // Bitwise ops
    always_comb begin
        case (ctrl.op)
            AND:     logic_res = op_a & op_b;
            OR:      logic_res = op_a | op_b;
            default: logic_res = op_a ^ op_b;
        endcase
    end

    polar_lanes u_polar (
        .a_i      (op_a),
        .b_i      (op_b),
        .op_i     (ctrl.op),
        .result_o (polar_res)
    );

    // --------------------
    // Result and branch
    // --------------------
    always_comb begin
        unique case (ctrl.unit)
            UNIT_ADDER: result_d = adder_sum[XLEN-1:0];
            UNIT_LOGIC: result_d = logic_res;
            UNIT_SHIFT: result_d = shift_out;
            UNIT_CMP:   result_d = ctrl.is_branch ? '0 : {{(XLEN - 1){1'b0}}, less};
            UNIT_POLAR: result_d = polar_res;
            default:    result_d = '0;
        endcase
    end

    always_comb begin
        branch_d = 1'b0;
        if (ctrl.is_branch) begin
            case (ctrl.op)
                EQ:      branch_d = adder_zero;
                NE:      branch_d = ~adder_zero;
                LT, LTU: branch_d = less;
                GE, GEU: branch_d = ~less;
                default: ;
            endcase
        end
    end

    // Response register, held until taken
    assign in_ready_o = ~resp_valid_o | resp_ready_i;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            resp_valid_o <= 1'b0;
        end else if (in_ready_o) begin
            resp_valid_o <= in_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (in_valid_i & in_ready_o) begin
            resp_o.result       <= result_d;
            resp_o.branch_taken <= branch_d;
        end
    end

endmodule

// File: source/alu_top.sv
// ALU pipeline top: decode stage, decoded item buffer and execute stage

`timescale 1ns/1ps

module alu_top (
    input  logic                    clk_i,
    input  logic                    reset_i,
    input  logic                    req_valid_i,
    input  alu_data_pkg::alu_req_t  req_i,
    output logic                    req_ready_o,
    output logic                    resp_valid_o,
    output alu_data_pkg::alu_resp_t resp_o,
    input  logic                    resp_ready_i
);

    import alu_ctrl_pkg::*;

    // Decode to buffer
    logic      dec_valid;
    logic      dec_ready;
    dec_item_t dec_item;

    // Buffer to execute
    logic      exe_valid;
    logic      exe_ready;
    dec_item_t exe_item;

    alu_decode u_decode (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .req_valid_i (req_valid_i),
        .req_i       (req_i),
        .req_ready_o (req_ready_o),
        .dec_valid_o (dec_valid),
        .dec_o       (dec_item),
        .dec_ready_i (dec_ready)
    );

    alu_buffer u_buffer (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .wr_valid_i (dec_valid),
        .wr_item_i  (dec_item),
        .wr_ready_o (dec_ready),
        .rd_valid_o (exe_valid),
        .rd_item_o  (exe_item),
        .rd_ready_i (exe_ready)
    );

    alu_execute u_execute (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .in_valid_i   (exe_valid),
        .in_item_i    (exe_item),
        .in_ready_o   (exe_ready),
        .resp_valid_o (resp_valid_o),
        .resp_o       (resp_o),
        .resp_ready_i (resp_ready_i)
    );

endmodule

// File: verification/alu_tb.sv
// Table-driven testbench for the ALU pipeline with random response back-pressure

`timescale 1ns/1ps

module alu_tb;

    import alu_ctrl_pkg::*;
    import alu_data_pkg::*;

    localparam int          HALF_PERIOD_NS   = 2;
    localparam int          CLK_PERIOD_NS    = 2 * HALF_PERIOD_NS;
    localparam int          RESET_CYCLES     = 5;
    localparam int          DRIVE_DELAY_NS   = 1;
    localparam int          CYCLES_PER_ENTRY = 20;
    localparam int          IDLE_CYCLES      = 12;
    localparam logic [31:0] LFSR_SEED        = 32'h652c;
    // x^32 + x^22 + x^2 + x + 1
    localparam logic [31:0] LFSR_TAPS        = 32'h8020_0003;

    typedef struct packed {
        alu_op_e op;
        word_t   a;
        word_t   b;
        word_t   exp_result;
        logic    exp_branch;
    } test_vector_t;

    logic         clk_i;
    logic         reset_i;
    logic         req_valid_i;
    alu_req_t     req_i;
    logic         req_ready_o;
    logic         resp_valid_o;
    alu_resp_t    resp_o;
    logic         resp_ready_i;

    test_vector_t table_q[$];
    int           num_entries;
    int           checked_count;
    bit           table_ready;
    logic [31:0]  lfsr_q;

    alu_top DUT (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .req_valid_i  (req_valid_i),
        .req_i        (req_i),
        .req_ready_o  (req_ready_o),
        .resp_valid_o (resp_valid_o),
        .resp_o       (resp_o),
        .resp_ready_i (resp_ready_i)
    );

    // --------------------
    // Helpers
    // --------------------
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ LFSR_TAPS) : (state >> 1);
    endfunction

    function automatic void add_entry(input alu_op_e op, input word_t a, input word_t b,
                                      input word_t result, input logic branch);
        table_q.push_back('{op: op, a: a, b: b, exp_result: result, exp_branch: branch});
    endfunction

    task automatic end_with_failure();
        $display("Verification failed");
        $fatal(1, "Stopping at the first failure");
    endtask

    // Expected values worked out by hand with lane 3 written first
    task automatic load_table();
        add_entry(ADD, 32'h0000_0005, 32'h0000_0007, 32'h0000_000c, 1'b0);
        add_entry(ADD, 32'hffff_ffff, 32'h0000_0001, 32'h0000_0000, 1'b0);
        add_entry(SUB, 32'h0000_0003, 32'h0000_0005, 32'hffff_fffe, 1'b0);
        add_entry(SUB, 32'h0000_0000, 32'h8000_0000, 32'h8000_0000, 1'b0);
        add_entry(AND, 32'hf0f0_1234, 32'h0ff0_ff00, 32'h00f0_1200, 1'b0);
        add_entry(OR,  32'hf0f0_1234, 32'h0ff0_ff00, 32'hfff0_ff34, 1'b0);
        add_entry(XOR, 32'hf0f0_1234, 32'h0ff0_ff00, 32'hff00_ed34, 1'b0);
        add_entry(SLL, 32'h8000_0001, 32'h0000_0000, 32'h8000_0001, 1'b0);
        add_entry(SLL, 32'h8000_0001, 32'h0000_0001, 32'h0000_0002, 1'b0);
        add_entry(SLL, 32'h0000_0001, 32'h0000_001f, 32'h8000_0000, 1'b0);
        add_entry(SRL, 32'h8765_4321, 32'h0000_0000, 32'h8765_4321, 1'b0);
        add_entry(SRL, 32'h8000_0000, 32'h0000_0001, 32'h4000_0000, 1'b0);
        add_entry(SRL, 32'h8000_0000, 32'h0000_001f, 32'h0000_0001, 1'b0);
        add_entry(SRA, 32'h8000_0000, 32'h0000_0001, 32'hc000_0000, 1'b0);
        add_entry(SRA, 32'h8000_0000, 32'h0000_001f, 32'hffff_ffff, 1'b0);
        add_entry(SRA, 32'h8765_4321, 32'h0000_0000, 32'h8765_4321, 1'b0);
        // Upper bits of b must not change the amount
        add_entry(SLL, 32'h0000_0003, 32'h0000_0021, 32'h0000_0006, 1'b0);
        add_entry(SRL, 32'hf000_0000, 32'hffff_ffe4, 32'h0f00_0000, 1'b0);
        add_entry(SLT,  32'h8000_0000, 32'h0000_0001, 32'h0000_0001, 1'b0);
        add_entry(SLTU, 32'h8000_0000, 32'h0000_0001, 32'h0000_0000, 1'b0);
        add_entry(EQ,  32'h0000_1234, 32'h0000_1234, 32'h0, 1'b1);
        add_entry(EQ,  32'h0000_1234, 32'h0000_1235, 32'h0, 1'b0);
        add_entry(NE,  32'h0000_0005, 32'h0000_0005, 32'h0, 1'b0);
        add_entry(NE,  32'h0000_0005, 32'h0000_0006, 32'h0, 1'b1);
        add_entry(LT,  32'hffff_ffff, 32'h0000_0001, 32'h0, 1'b1);
        add_entry(LT,  32'h0000_0001, 32'hffff_ffff, 32'h0, 1'b0);
        add_entry(GE,  32'h0000_0001, 32'hffff_ffff, 32'h0, 1'b1);
        add_entry(GE,  32'hffff_ffff, 32'h0000_0001, 32'h0, 1'b0);
        add_entry(GE,  32'h0000_0007, 32'h0000_0007, 32'h0, 1'b1);
        add_entry(LTU, 32'h0000_0001, 32'hffff_ffff, 32'h0, 1'b1);
        add_entry(LTU, 32'hffff_ffff, 32'h0000_0001, 32'h0, 1'b0);
        add_entry(GEU, 32'hffff_ffff, 32'h0000_0001, 32'h0, 1'b1);
        add_entry(GEU, 32'h0000_0001, 32'hffff_ffff, 32'h0, 1'b0);
        add_entry(PL_F,      32'h05fa_8010, 32'hfdfa_7f10, 32'hfd06_8110, 1'b0);
        add_entry(PL_F,      32'h8080_0100, 32'h807f_ff00, 32'h8081_ff00, 1'b0);
        add_entry(PL_R,      32'h80ff_05f0, 32'h0102_0000, 32'h0001_0001, 1'b0);
        add_entry(PL_ADDSAT, 32'h7090_1081, 32'h2090_f0ff, 32'h7f81_0081, 1'b0);
        add_entry(PL_ADDSAT, 32'h017f_8040, 32'h0200_013f, 32'h037f_817f, 1'b0);
        add_entry(PL_SUBSAT, 32'h807f_0510, 32'h0181_0af0, 32'h817f_fb20, 1'b0);
        add_entry(PL_SUBSAT, 32'h0081_4000, 32'h8000_4100, 32'h7f81_ff00, 1'b0);
    endtask

    // Called just after a rising edge and returns just after the accepting edge
    task automatic send_request(input test_vector_t entry);
        req_valid_i = 1'b1;
        req_i.op    = entry.op;
        req_i.a     = entry.a;
        req_i.b     = entry.b;
        @(negedge clk_i);
        while (!req_ready_o) begin
            @(negedge clk_i);
        end
        @(posedge clk_i);
        #DRIVE_DELAY_NS;
    endtask

    // --------------------
    // Clock and stimulus
    // --------------------
    initial begin
        clk_i = 1'b0;
        forever #HALF_PERIOD_NS clk_i = ~clk_i;
    end

    initial begin
        reset_i     = 1'b1;
        req_valid_i = 1'b0;
        req_i       = '0;
        load_table();
        num_entries = table_q.size();
        table_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_i);
        #DRIVE_DELAY_NS;
        reset_i = 1'b0;
        foreach (table_q[i]) begin
            send_request(table_q[i]);
        end
        req_valid_i = 1'b0;
        while (checked_count != num_entries) begin
            @(posedge clk_i);
        end
        // Quiet period so a stray response would still be caught
        repeat (IDLE_CYCLES) @(posedge clk_i);
        $display("Verification passed");
        $finish;
    end

    // Random back-pressure with one LFSR step per cycle
    initial begin
        resp_ready_i = 1'b0;
        lfsr_q       = LFSR_SEED;
        forever begin
            @(posedge clk_i);
            #DRIVE_DELAY_NS;
            lfsr_q       = lfsr_step(lfsr_q);
            resp_ready_i = lfsr_q[0];
        end
    end

    // --------------------
    // Response checker
    // --------------------
    initial begin : response_checker
        test_vector_t expected;
        logic         was_reset;
        checked_count = 0;
        was_reset     = 1'b1;
        forever begin
            @(negedge clk_i);
            if (reset_i || was_reset) begin
                assert (resp_valid_o === 1'b0) else begin
                    $display("[ERROR] resp_valid_o: got 0x%h, expected 0x0 around reset",
                             resp_valid_o);
                    end_with_failure();
                end
            end else if (resp_valid_o) begin
                assert (checked_count < num_entries) else begin
                    $display("A response appeared after all %0d entries were answered",
                             num_entries);
                    end_with_failure();
                end
                if (resp_ready_i) begin
                    expected = table_q[checked_count];
                    assert (resp_o.result === expected.exp_result) else begin
                        $display("[ERROR] resp_o.result: entry %0d (%s) got 0x%h, expected 0x%h",
                                 checked_count, expected.op.name(), resp_o.result,
                                 expected.exp_result);
                        end_with_failure();
                    end
                    assert (resp_o.branch_taken === expected.exp_branch) else begin
                        $display(
                            "[ERROR] resp_o.branch_taken: entry %0d (%s) got 0x%h, expected 0x%h",
                            checked_count, expected.op.name(), resp_o.branch_taken,
                            expected.exp_branch);
                        end_with_failure();
                    end
                    checked_count++;
                end
            end
            was_reset = reset_i;
        end
    end

    // Watchdog sized from the table length
    initial begin
        wait (table_ready);
        #((num_entries * CYCLES_PER_ENTRY + RESET_CYCLES) * CLK_PERIOD_NS);
        $display("Timeout: responses stopped arriving after %0d of %0d entries",
                 checked_count, num_entries);
        end_with_failure();
    end

endmodule

// File: project.f
+incdir+source
source/alu_ctrl_pkg.sv
source/alu_data_pkg.sv
source/polar_lanes.sv
source/alu_decode.sv
source/alu_buffer.sv
source/alu_execute.sv
source/alu_top.sv
verification/alu_tb.sv

// File: Makefile
# Verilator flow for the ALU pipeline

VERILATOR   ?= verilator
TOP         ?= alu_tb
FILELIST    ?= project.f
BUILD_DIR   ?= obj_dir
LOG         ?= sim.log
PASS_TEXT   ?= Verification passed
JOBS        ?= 4
LINT_FLAGS  ?= --lint-only --timing --assert
BUILD_FLAGS ?= --binary --timing --assert -Wno-fatal -j $(JOBS)

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(BUILD_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qx "$(PASS_TEXT)" $(LOG); then \
		echo "Simulation PASS"; \
	else \
		echo "Simulation FAIL, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
